// File: common/gmii_tx_if.sv
// GMII transmit byte stream from the frame buffer to the DDR encoder, with its clock enable
`timescale 1ns/1ns

interface gmii_tx_if;

    logic [7:0] txd;
    logic       tx_en;
    logic       tx_er;
    // High in cycles where a new GMII byte may be presented
    // Driven by the transmit clock generator
    logic       clk_en;

    modport source (
        output txd,
        output tx_en,
        output tx_er,
        input  clk_en
    );

    modport sink (
        input txd,
        input tx_en,
        input tx_er
    );

endinterface

// File: common/rgmii_pkg.sv
// Speed codes, transmit buffer sizing and receive capture layout shared by the RGMII port
package rgmii_pkg;

    // Link speed codes
    // Code 3 is decoded as gigabit everywhere
    localparam logic [1:0] SPEED_10   = 2'd0;
    localparam logic [1:0] SPEED_100  = 2'd1;
    localparam logic [1:0] SPEED_1000 = 2'd2;

    // Transmit buffer slots, equal to the credits the MAC owns after reset
    localparam int TX_BUF_DEPTH = 16;
    localparam int TX_BUF_AW    = 4;

    // 10 Mb/s transmit clock, 2.5 MHz out of a 125 MHz clk
    localparam int DIV10_HALF   = 25;
    localparam int DIV10_PERIOD = 50;

    // 100 Mb/s transmit clock, 25 MHz out of a 125 MHz clk
    // Odd period, so the high phase ends on a half cycle
    localparam int DIV100_HALF   = 3;
    localparam int DIV100_PERIOD = 5;

    // One receive capture, rising and falling halves of a phy_rx_clk cycle
    // Gigabit view sees one byte, low nibble taken on the rising edge
    // MII view keeps the two nibbles apart, both carry the same nibble at 10/100
    typedef union packed {
        struct packed {
            logic [7:0] data;
            logic       ctl_rise;
            logic       ctl_fall;
        } gig;
        struct packed {
            logic [3:0] nib_fall;
            logic [3:0] nib_rise;
            logic       ctl_rise;
            logic       ctl_fall;
        } mii;
    } rgmii_rx_word_u;

endpackage

// File: common/tx_phase_if.sv
// Transmit clock phase bundle, driven by the clock generator and read by the DDR encoder
`timescale 1ns/1ns

interface tx_phase_if;

    // Output clock level in the first half of the current clk cycle
    logic clk_hi1;
    // Output clock level in the second half
    logic clk_hi2;
    // One-cycle mark, output clock has just risen
    logic rise;
    // One-cycle mark, output clock has just fallen
    logic fall;

    modport source (
        output clk_hi1,
        output clk_hi2,
        output rise,
        output fall
    );

    // Encoder needs the levels and the rising mark only
    modport sink (
        input clk_hi1,
        input clk_hi2,
        input rise
    );

endinterface

// File: rgmii_phy/rx_ddr_decoder.sv
// RGMII receive decoder that captures both phy_rx_clk edges and rebuilds GMII receive bytes
`timescale 1ns/1ns

module rx_ddr_decoder
    import rgmii_pkg::*;
(
    input  logic       rst,
    input  logic       phy_rx_clk,
    input  logic [3:0] phy_rxd,
    input  logic       phy_rx_ctl,
    output logic [7:0] rx_data,
    output logic       rx_dv,
    output logic       rx_er,
    output logic       rx_rst
);

    logic [3:0]     rise_nib;
    logic           rise_ctl;
    logic [3:0]     fall_nib;
    logic           fall_ctl;
    rgmii_rx_word_u cap_word;
    rgmii_rx_word_u word_q;
    logic [3:0]     rst_sync;

    // Rising half, low nibble and rx_dv
    always_ff @(posedge phy_rx_clk) begin
        rise_nib <= phy_rxd;
        rise_ctl <= phy_rx_ctl;
    end

    // Falling half, high nibble and rx_dv xor rx_er
    always_ff @(negedge phy_rx_clk) begin
        fall_nib <= phy_rxd;
        fall_ctl <= phy_rx_ctl;
    end

    // Pack the two halves nibble by nibble
    always_comb begin
        cap_word.mii.nib_rise = rise_nib;
        cap_word.mii.ctl_rise = rise_ctl;
        cap_word.mii.nib_fall = fall_nib;
        cap_word.mii.ctl_fall = fall_ctl;
    end

    // Whole cycle registered on the next rising edge
    always_ff @(posedge phy_rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            word_q <= '0;
        end else begin
            word_q <= cap_word;
        end
    end

    // Read back as one byte
    assign rx_data = word_q.gig.data;
    assign rx_dv   = word_q.gig.ctl_rise;
    assign rx_er   = word_q.gig.ctl_rise ^ word_q.gig.ctl_fall;

    // Asserts with rst, releases after four phy_rx_clk rising edges
    always_ff @(posedge phy_rx_clk or posedge rst) begin
        if (rst) begin
            rst_sync <= 4'hf;
        end else begin
            rst_sync <= {1'b0, rst_sync[3:1]};
        end
    end

    assign rx_rst = rst_sync[0];

endmodule

// File: rgmii_phy/tx_clock_gen.sv
// RGMII transmit clock pattern and byte enable for 10, 100 and 1000 Mb/s, from a 125 MHz clk
`timescale 1ns/1ns

module tx_clock_gen
    import rgmii_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] speed,
    tx_phase_if.source phase,
    output logic       clk_en
);

    logic [5:0] div_cnt;
    logic [5:0] half_cnt;
    logic [5:0] last_cnt;
    logic       slow_mode;
    logic       odd_period;
    logic       hi1_q;
    logic       hi2_q;
    logic       rise_q;
    logic       fall_q;

    // Divider terminal counts for the selected speed
    always_comb begin
        slow_mode  = 1'b1;
        odd_period = 1'b0;
        half_cnt   = 6'(DIV10_HALF - 1);
        last_cnt   = 6'(DIV10_PERIOD - 1);
        case (speed)
            SPEED_10: begin
                half_cnt = 6'(DIV10_HALF - 1);
                last_cnt = 6'(DIV10_PERIOD - 1);
            end
            SPEED_100: begin
                half_cnt   = 6'(DIV100_HALF - 1);
                last_cnt   = 6'(DIV100_PERIOD - 1);
                odd_period = 1'b1;
            end
            // Gigabit and code 3
            default: slow_mode = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            hi1_q   <= 1'b1;
            hi2_q   <= 1'b0;
            rise_q  <= 1'b1;
            fall_q  <= 1'b1;
        end else if (!slow_mode) begin
            // One full output clock per clk cycle
            div_cnt <= '0;
            hi1_q   <= 1'b1;
            hi2_q   <= 1'b0;
            rise_q  <= 1'b1;
            fall_q  <= 1'b1;
        end else begin
            // Level carries over from the second half of the previous cycle
            hi1_q   <= hi2_q;
            rise_q  <= 1'b0;
            fall_q  <= 1'b0;
            div_cnt <= div_cnt + 1'b1;
            if (div_cnt == half_cnt) begin
                hi1_q  <= 1'b1;
                hi2_q  <= 1'b1;
                rise_q <= 1'b1;
            end else if (div_cnt >= last_cnt) begin
                // Odd period falls mid cycle, first half stays high
                hi2_q <= 1'b0;
                if (!odd_period) begin
                    hi1_q <= 1'b0;
                end
                fall_q  <= 1'b1;
                div_cnt <= '0;
            end
        end
    end

    assign phase.clk_hi1 = hi1_q;
    assign phase.clk_hi2 = hi2_q;
    assign phase.rise    = rise_q;
    assign phase.fall    = fall_q;

    // Next GMII byte is taken once per output clock, at its falling mark
    assign clk_en = phase.fall;

endmodule

// File: rgmii_phy/tx_ddr_encoder.sv
// GMII to RGMII transmit encoder with behavioral double-edge output registers
`timescale 1ns/1ns

module tx_ddr_encoder
    import rgmii_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] speed,
    gmii_tx_if.sink    gmii,
    tx_phase_if.sink   phase,
    output logic       phy_tx_clk,
    output logic [3:0] phy_txd,
    output logic       phy_tx_ctl
);

    logic [1:0] speed_q;
    logic       gig_mode;
    logic       mii_ctl;
    // Half words {nibble, ctl}
    logic [4:0] d_rise;
    logic [4:0] d_fall;
    // DDR state {clk, nibble, ctl}
    logic [5:0] pos_q;
    logic [5:0] neg_q;
    logic [5:0] fall_hold;
    logic [5:0] ddr_out;

    assign gig_mode = !(speed_q == SPEED_10 || speed_q == SPEED_100);

    // 10/100 control bit is tx_en while the output clock is high
    assign mii_ctl = phase.clk_hi2 ? gmii.tx_en : (gmii.tx_en ^ gmii.tx_er);

    always_comb begin
        if (gig_mode) begin
            d_rise = {gmii.txd[3:0], gmii.tx_en};
            d_fall = {gmii.txd[7:4], gmii.tx_en ^ gmii.tx_er};
        end else begin
            // Nibble repeated on both halves
            d_rise = {gmii.txd[3:0], mii_ctl};
            d_fall = {gmii.txd[3:0], mii_ctl};
        end
    end

    // Rising half, falling half held for the next negedge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            speed_q   <= SPEED_1000;
            pos_q     <= '0;
            fall_hold <= '0;
        end else begin
            // Mode change lands on an output clock rising boundary
            if (phase.rise) begin
                speed_q <= speed;
            end
            pos_q     <= {phase.clk_hi1, d_rise} ^ neg_q;
            fall_hold <= {phase.clk_hi2, d_fall};
        end
    end

    always_ff @(negedge clk or posedge rst) begin
        if (rst) begin
            neg_q <= '0;
        end else begin
            neg_q <= fall_hold ^ pos_q;
        end
    end

    // XOR pair gives the rising half after posedge, the falling half after negedge
    assign ddr_out = pos_q ^ neg_q;

    assign phy_tx_clk = ddr_out[5];
    assign phy_txd    = ddr_out[4:1];
    assign phy_tx_ctl = ddr_out[0];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the RGMII port testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_rgmii_port -f vlog.f -o tb_rgmii_port \
    && ./obj_dir/tb_rgmii_port | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

// File: source/rgmii_port.sv
// Tri-speed RGMII port top level, MAC transmit and receive on plain ports, PHY pins out
`timescale 1ns/1ns

module rgmii_port (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] speed,
    // MAC transmit side, credit flow control
    input  logic [7:0] tx_data,
    input  logic       tx_err,
    input  logic       tx_last,
    input  logic       tx_valid,
    output logic       tx_credit,
    // PHY transmit pins
    output logic       phy_tx_clk,
    output logic [3:0] phy_txd,
    output logic       phy_tx_ctl,
    // PHY receive pins
    input  logic       phy_rx_clk,
    input  logic [3:0] phy_rxd,
    input  logic       phy_rx_ctl,
    // MAC receive side, phy_rx_clk domain
    output logic [7:0] rx_data,
    output logic       rx_dv,
    output logic       rx_er,
    output logic       rx_rst
);

    gmii_tx_if  gmii_bus ();
    tx_phase_if phase_bus ();

    tx_frame_buffer u_tx_frame_buffer (
        .clk       (clk),
        .rst       (rst),
        .tx_data   (tx_data),
        .tx_err    (tx_err),
        .tx_last   (tx_last),
        .tx_valid  (tx_valid),
        .tx_credit (tx_credit),
        .gmii      (gmii_bus)
    );

    // Clock enable goes straight into the GMII bundle
    tx_clock_gen u_tx_clock_gen (
        .clk    (clk),
        .rst    (rst),
        .speed  (speed),
        .phase  (phase_bus),
        .clk_en (gmii_bus.clk_en)
    );

    tx_ddr_encoder u_tx_ddr_encoder (
        .clk        (clk),
        .rst        (rst),
        .speed      (speed),
        .gmii       (gmii_bus),
        .phase      (phase_bus),
        .phy_tx_clk (phy_tx_clk),
        .phy_txd    (phy_txd),
        .phy_tx_ctl (phy_tx_ctl)
    );

    rx_ddr_decoder u_rx_ddr_decoder (
        .rst        (rst),
        .phy_rx_clk (phy_rx_clk),
        .phy_rxd    (phy_rxd),
        .phy_rx_ctl (phy_rx_ctl),
        .rx_data    (rx_data),
        .rx_dv      (rx_dv),
        .rx_er      (rx_er),
        .rx_rst     (rx_rst)
    );

endmodule

// File: source/tx_frame_buffer.sv
// Credited byte FIFO that holds transmit frames and sends each complete one out as GMII
`timescale 1ns/1ns

module tx_frame_buffer
    import rgmii_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_err,
    input  logic       tx_last,
    input  logic       tx_valid,
    output logic       tx_credit,
    gmii_tx_if.source  gmii
);

    // Entry layout {err, last, data}
    logic [9:0]           buf_mem [TX_BUF_DEPTH];
    logic [9:0]           rd_entry;
    logic [TX_BUF_AW-1:0] wr_ptr;
    logic [TX_BUF_AW-1:0] rd_ptr;
    // Frame ends stored and not yet sent, up to one per slot
    logic [TX_BUF_AW:0]   frame_cnt;
    logic                 in_frame;
    logic                 frame_ready;
    logic                 pop;
    logic                 push_last;
    logic                 pop_last;

    assign rd_entry = buf_mem[rd_ptr];

    // New frame only after an idle GMII slot, so tx_en drops between frames
    assign frame_ready = (frame_cnt != '0) && !gmii.tx_en;
    assign pop         = gmii.clk_en && (in_frame || frame_ready);
    assign push_last   = tx_valid && tx_last;
    assign pop_last    = pop && rd_entry[8];

    // One credit back per byte leaving the buffer
    assign tx_credit = pop;

    // Source holds a credit for every byte, no full check
    always_ff @(posedge clk) begin
        if (tx_valid) begin
            buf_mem[wr_ptr] <= {tx_err, tx_last, tx_data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
            in_frame  <= 1'b0;
        end else begin
            if (tx_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                // Stay in the frame until its last byte goes out
                in_frame <= !rd_entry[8];
            end
            case ({push_last, pop_last})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    // GMII control, updated once per byte slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gmii.tx_en <= 1'b0;
            gmii.tx_er <= 1'b0;
        end else if (gmii.clk_en) begin
            gmii.tx_en <= pop;
            gmii.tx_er <= pop && rd_entry[9];
        end
    end

    // Byte of the entry being popped, feeds the XOR pair of the DDR encoder
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gmii.txd <= '0;
        end else if (pop) begin
            gmii.txd <= rd_entry[7:0];
        end
    end

endmodule

// File: verification/rgmii_stim.txt
// Columns: speed (0=10, 1=100, 2=1000, 3=1000 Mb/s), data byte in hex, error flag, last flag
// One line per transmitted byte, speed only changes after a last byte
2 55 0 0
2 55 0 0
2 55 0 0
2 d5 0 0
2 a1 0 0
2 3c 0 0
2 ff 0 0
2 00 0 0
2 7e 1 0
2 81 0 1
2 12 0 0
2 34 1 0
2 56 0 0
2 78 0 1
1 0f 0 0
1 a5 0 0
1 c3 0 0
1 96 0 0
1 e1 0 0
1 5b 0 1
0 69 0 0
0 f0 0 0
0 2d 0 0
0 8c 0 1
3 de 0 0
3 ad 1 0
3 be 0 0
3 ef 0 1

// File: verification/tb_rgmii_port.sv
// Testbench for the RGMII port, file-driven credited transmit looped back into the receive side
`timescale 1ns/1ns

module tb_rgmii_port
    import rgmii_pkg::*;
();

    logic       clk;
    logic       rst;
    logic [1:0] speed;
    logic [7:0] tx_data;
    logic       tx_err;
    logic       tx_last;
    logic       tx_valid;
    logic       tx_credit;
    logic       phy_tx_clk;
    logic [3:0] phy_txd;
    logic       phy_tx_ctl;
    logic       phy_rx_clk;
    logic [3:0] phy_rxd;
    logic       phy_rx_ctl;
    logic [7:0] rx_data;
    logic       rx_dv;
    logic       rx_er;
    logic       rx_rst;

    // Stimulus lines, one entry per byte
    logic [1:0]     stim_speed [$];
    logic [7:0]     stim_data [$];
    logic           stim_err [$];
    logic           stim_last [$];
    bit             stim_loaded = 1'b0;
    // Scoreboard entries {err, byte}
    logic [8:0]     expect_q [$];
    int             bytes_sent = 0;
    int             credits_back = 0;
    bit             first_frame_sent = 1'b0;
    rgmii_rx_word_u rx_word;
    logic [8:0]     rx_expect;

    rgmii_port u_rgmii_port (
        .clk        (clk),
        .rst        (rst),
        .speed      (speed),
        .tx_data    (tx_data),
        .tx_err     (tx_err),
        .tx_last    (tx_last),
        .tx_valid   (tx_valid),
        .tx_credit  (tx_credit),
        .phy_tx_clk (phy_tx_clk),
        .phy_txd    (phy_txd),
        .phy_tx_ctl (phy_tx_ctl),
        .phy_rx_clk (phy_rx_clk),
        .phy_rxd    (phy_rxd),
        .phy_rx_ctl (phy_rx_ctl),
        .rx_data    (rx_data),
        .rx_dv      (rx_dv),
        .rx_er      (rx_er),
        .rx_rst     (rx_rst)
    );

    // Loopback, clock trails data by 2 ns in place of the clk90 path
    assign #2 phy_rx_clk = phy_tx_clk;
    assign phy_rxd    = phy_txd;
    assign phy_rx_ctl = phy_tx_ctl;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [7:0] expected_byte(input logic [1:0] code, input logic [7:0] data);
        // 10/100 repeats the low nibble in both halves
        if (code == SPEED_10 || code == SPEED_100) begin
            return {data[3:0], data[3:0]};
        end
        return data;
    endfunction

    function automatic int credit_balance();
        return TX_BUF_DEPTH - bytes_sent + credits_back;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_rx(input rgmii_rx_word_u got, input logic [7:0] exp_data,
                            input logic exp_err);
        logic got_err;
        got_err = got.gig.ctl_rise ^ got.gig.ctl_fall;
        if (got.gig.data !== exp_data) begin
            fail_run($sformatf("Error at %0t ns: rx_data expected %02h, actual %02h",
                               $time, exp_data, got.gig.data));
        end
        if (got_err !== exp_err) begin
            fail_run($sformatf("Error at %0t ns: rx_er expected %0b, actual %0b",
                               $time, exp_err, got_err));
        end
    endtask

    task automatic check_credit(input string name, input int expected, input int actual);
        if (expected != actual) begin
            fail_run($sformatf("Error at %0t ns: %s expected %0d, actual %0d",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_rx_rst(input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t ns: rx_rst expected %0b, actual %0b",
                               $time, expected, actual));
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    sp;
        int    data;
        int    err;
        int    last;
        string line;
        fd = $fopen("verification/rgmii_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file verification/rgmii_stim.txt");
        end
        // Header lines do not parse and are skipped
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %h %d %d", sp, data, err, last) == 4) begin
                stim_speed.push_back(sp[1:0]);
                stim_data.push_back(data[7:0]);
                stim_err.push_back(err[0]);
                stim_last.push_back(last[0]);
            end
        end
        $fclose(fd);
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic send_byte(input logic [1:0] code, input logic [7:0] data,
                             input logic err, input logic last);
        while (credit_balance() <= 0) begin
            tx_valid = 1'b0;
            @(posedge clk);
            #2;
        end
        tx_data    = data;
        tx_err     = err;
        tx_last    = last;
        tx_valid   = 1'b1;
        bytes_sent = bytes_sent + 1;
        expect_q.push_back({err, expected_byte(code, data)});
        if (last) begin
            first_frame_sent = 1'b1;
        end
        @(posedge clk);
        #2;
        tx_valid = 1'b0;
    endtask

    // Every byte back, each one popped earlier, so all credits are home
    task automatic drain_transmit();
        tx_valid = 1'b0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
        check_credit("credit balance", TX_BUF_DEPTH, credit_balance());
    endtask

    // Credit pulses counted mid cycle
    always @(negedge clk) begin
        if (rx_dv === 1'b1 && !first_frame_sent) begin
            fail_run("rx_dv went high before the first frame had been sent");
        end
        if (tx_credit === 1'b1) begin
            if (!first_frame_sent) begin
                fail_run("tx_credit pulsed before the first frame had been sent");
            end
            credits_back = credits_back + 1;
            if (credits_back > bytes_sent) begin
                fail_run("More tx_credit pulses than bytes sent");
            end
        end
    end

    // rx outputs settle at the rising edge, read them at the falling one
    always @(negedge phy_rx_clk) begin
        if (rx_dv === 1'b1) begin
            if (!first_frame_sent) begin
                fail_run("A byte was received before the first frame had been sent");
            end else if (expect_q.size() == 0) begin
                fail_run("A byte was received that was never sent");
            end else begin
                rx_expect = expect_q.pop_front();
                // Capture word rebuilt from the MAC side outputs
                rx_word.gig.data     = rx_data;
                rx_word.gig.ctl_rise = rx_dv;
                rx_word.gig.ctl_fall = rx_dv ^ rx_er;
                check_rx(rx_word, rx_expect[7:0], rx_expect[8]);
            end
        end
    end

    // Slowest byte is one 10 Mb/s period, doubled, plus reset and speed changes
    initial begin
        wait (stim_loaded);
        repeat (stim_data.size() * DIV10_PERIOD * 2 + 1000) @(posedge clk);
        fail_run("Timeout: the run did not finish within the expected number of cycles");
    end

    initial begin
        rst      = 1'b0;
        speed    = SPEED_1000;
        tx_data  = '0;
        tx_err   = 1'b0;
        tx_last  = 1'b0;
        tx_valid = 1'b0;
        load_stimulus();
        if (stim_data.size() == 0) begin
            fail_run("The stimulus file holds no bytes");
        end
        stim_loaded = 1'b1;
        // phy_rx_clk is still during reset, the rst edge alone sets the synchronizer
        #2;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        check_rx_rst(1'b1, rx_rst);
        rst = 1'b0;
        // Receive reset still high after three phy_rx_clk rising edges, low after four
        repeat (3) @(posedge phy_rx_clk);
        #1;
        check_rx_rst(1'b1, rx_rst);
        @(posedge phy_rx_clk);
        #1;
        check_rx_rst(1'b0, rx_rst);
        @(posedge clk);
        #2;
        for (int i = 0; i < stim_data.size(); i++) begin
            if (stim_speed[i] != speed) begin
                if (i > 0 && !stim_last[i-1]) begin
                    fail_run("The stimulus file changes speed inside a frame");
                end
                drain_transmit();
                speed = stim_speed[i];
                // Transmit clock settles into the new rate
                repeat (2 * DIV10_PERIOD) @(posedge clk);
                #2;
            end
            send_byte(stim_speed[i], stim_data[i], stim_err[i], stim_last[i]);
        end
        drain_transmit();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
common/rgmii_pkg.sv
common/tx_phase_if.sv
common/gmii_tx_if.sv
source/tx_frame_buffer.sv
rgmii_phy/tx_clock_gen.sv
rgmii_phy/tx_ddr_encoder.sv
rgmii_phy/rx_ddr_decoder.sv
source/rgmii_port.sv
verification/tb_rgmii_port.sv
